// File: vlog.f
design/fetch_pkg.sv
design/fetch_stream_if.sv
design/sync_fifo.sv
design/pc_unit.sv
design/fetch_axi_master.sv
design/early_branch.sv
design/fetch_top.sv
dv/tb_fetch_top.sv

// File: dv/tb_fetch_top.sv
module tb_fetch_top;

    // Table entry kinds
    localparam logic [3:0] k_mem    = 4'd0;
    localparam logic [3:0] k_fault  = 4'd1;
    localparam logic [3:0] k_ex     = 4'd2;
    localparam logic [3:0] k_misp   = 4'd3;
    localparam logic [3:0] k_csr_ex = 4'd4;
    localparam logic [3:0] k_stall  = 4'd5;
    localparam logic [3:0] k_fence  = 4'd6;
    localparam logic [3:0] k_end    = 4'd7;

    localparam int          n_entries     = 10;
    localparam int          timeout_limit = n_entries * 200 + 50;
    localparam int          skip_limit    = 9;
    localparam logic [31:0] filler        = 32'h0010_8093;

    typedef struct packed {
        logic [3:0]  kind;
        logic [31:0] count;
        logic [31:0] a;
        logic [31:0] b;
    } entry_t;

    logic        clk;
    logic        rst;
    logic        csr_redirect;
    logic [31:0] csr_target;
    logic        ex_redirect;
    logic        ex_mispredict;
    logic [31:0] ex_target;
    logic [31:0] ex_saved_pc;
    logic [1:0]  hazard;
    logic        fence;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        instr_valid;
    logic        instr_ready;
    logic [31:0] instr_pc;
    logic [31:0] instr_data;
    logic        instr_pred_taken;
    logic        instr_fault;

    entry_t      tbl [n_entries];
    logic [31:0] mem_words [logic [31:0]];
    bit          fault_addr [logic [31:0]];
    logic [31:0] ar_q [$];
    logic [31:0] rng;
    logic [31:0] exp_pc;
    logic        prev_arvalid;
    bit          resync;
    bit          finished;
    int          rsp_delay;
    int          in_flight;
    int          delivered;
    int          ev_idx;
    int          hold;
    int          skipped;
    int          reset_count;
    int          cycles;

    fetch_top u_dut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return mem_words.exists(addr) ? mem_words[addr] : filler;
    endfunction

    // JAL always, conditional branch only when the offset is negative
    function automatic logic predict(input logic [31:0] w, input logic flt);
        if (flt) return 1'b0;
        return (w[6:0] == 7'b1101111) || ((w[6:0] == 7'b1100011) && w[31]);
    endfunction

    function automatic logic [31:0] jump_target(input logic [31:0] w, input logic [31:0] pc);
        logic [31:0] imm_j;
        logic [31:0] imm_b;
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        return pc + ((w[6:0] == 7'b1101111) ? imm_j : imm_b);
    endfunction

    function automatic int next_event(input int from);
        int i;
        i = from;
        while (i < n_entries && (tbl[i].kind == k_mem || tbl[i].kind == k_fault)) i++;
        return i;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic report_error(input string what);
        $display("t=%0t: %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic expect_pc(input logic [31:0] target);
        exp_pc  = target;
        resync  = 1'b1;
        skipped = 0;
    endtask

    ////////////////////////////////////////
    // Back-end events
    ////////////////////////////////////////
    task automatic apply_events();
        entry_t e;
        if (ev_idx >= n_entries) return;
        e = tbl[ev_idx];
        if (delivered < int'(e.count)) return;
        case (e.kind)
            k_ex: begin
                ex_redirect = 1'b1;
                ex_target   = e.a;
                expect_pc(e.a);
            end
            k_misp: begin
                ex_redirect   = 1'b1;
                ex_mispredict = 1'b1;
                ex_saved_pc   = e.a;
                ex_target     = e.a + 32'h80;
                expect_pc(e.a + 32'd4);
            end
            k_csr_ex: begin
                csr_redirect = 1'b1;
                csr_target   = e.a;
                ex_redirect  = 1'b1;
                ex_target    = e.b;
                expect_pc(e.a);
            end
            k_stall: begin
                hazard = fetch_pkg::hazard_stall_early;
                hold   = e.a;
            end
            k_fence: begin
                fence = 1'b1;
                hold  = e.a;
            end
            default: finished = 1'b1;
        endcase
        if (e.kind != k_end) ev_idx = next_event(ev_idx + 1);
    endtask

    ////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////
    task automatic drive_read_data();
        logic [31:0] addr;
        rvalid = 1'b0;
        if (ar_q.size() == 0) return;
        if (rsp_delay > 0) begin
            rsp_delay--;
        end else begin
            addr   = ar_q.pop_front();
            rvalid = 1'b1;
            assert (rready) else report_mismatch("rready", rready, 1'b1);
            rdata  = word_at(addr);
            rresp  = fault_addr.exists(addr) ? 2'b10 : 2'b00;
            in_flight--;
            rng       = xorshift(rng);
            rsp_delay = rng % 4;
        end
    endtask

    task automatic drive_read_addr();
        rng     = xorshift(rng);
        arready = (rng % 4) != 0;
        if (arvalid && arready) begin
            ar_q.push_back(araddr);
            in_flight++;
            assert (in_flight <= fetch_pkg::max_outstanding)
                else report_error("more reads in flight than the credit limit");
        end
    endtask

    // Skips packets in the shadow of a redirect, then follows the predicted path
    task automatic check_packet();
        logic taken;
        assert (instr_data == word_at(instr_pc))
            else report_mismatch("instr_data", instr_data, word_at(instr_pc));
        assert (instr_fault == fault_addr.exists(instr_pc))
            else report_mismatch("instr_fault", instr_fault, fault_addr.exists(instr_pc));
        if (resync && instr_pc != exp_pc) begin
            skipped++;
            assert (skipped <= skip_limit)
                else report_error("delivery never resumed at the redirect target");
        end else begin
            resync = 1'b0;
            assert (instr_pc == exp_pc) else report_mismatch("instr_pc", instr_pc, exp_pc);
            taken = predict(word_at(instr_pc), fault_addr.exists(instr_pc));
            assert (instr_pred_taken == taken)
                else report_mismatch("instr_pred_taken", instr_pred_taken, taken);
            if (taken) expect_pc(jump_target(word_at(instr_pc), instr_pc));
            else exp_pc = instr_pc + 32'd4;
        end
        delivered++;
    endtask

    always @(negedge clk) begin
        if (reset_count < 10) begin
            reset_count++;
            if (reset_count == 10) rst = 1'b0;
        end else begin
            // No new request may rise while the last edge saw a stall
            if (hazard != fetch_pkg::hazard_none || fence) begin
                assert (!(arvalid && !prev_arvalid))
                    else report_error("arvalid rose while fetch was stalled");
            end
            prev_arvalid  = arvalid;
            csr_redirect  = 1'b0;
            ex_redirect   = 1'b0;
            ex_mispredict = 1'b0;
            if (hold > 0) begin
                hold--;
                if (hold == 0) begin
                    hazard = fetch_pkg::hazard_none;
                    fence  = 1'b0;
                end
            end
            apply_events();
            drive_read_data();
            drive_read_addr();
            rng         = xorshift(rng);
            instr_ready = (rng % 4) != 0;
            if (instr_valid && instr_ready) check_packet();
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        csr_redirect = 1'b0;
        csr_target = '0;
        ex_redirect = 1'b0;
        ex_mispredict = 1'b0;
        ex_target = '0;
        ex_saved_pc = '0;
        hazard = fetch_pkg::hazard_none;
        fence = 1'b0;
        arready = 1'b0;
        rdata = '0;
        rresp = 2'b00;
        rvalid = 1'b0;
        instr_ready = 1'b0;
        rng = 32'h35d760c2;
        exp_pc = fetch_pkg::reset_pc;
        prev_arvalid = 1'b0;
        resync = 1'b0;
        finished = 1'b0;
        rsp_delay = 0;
        in_flight = 0;
        delivered = 0;
        hold = 0;
        reset_count = 0;

        // Program words first, then back-end events by packet count
        tbl[0] = '{k_mem,    32'd0,  32'h0000_0010, 32'h0300_006f};
        tbl[1] = '{k_mem,    32'd0,  32'h0000_0040, 32'h0000_0863};
        tbl[2] = '{k_mem,    32'd0,  32'h0000_0048, 32'hfe00_0ce3};
        tbl[3] = '{k_fault,  32'd0,  32'h0000_0104, 32'h0300_006f};
        tbl[4] = '{k_ex,     32'd12, 32'h0000_0100, 32'h0};
        tbl[5] = '{k_stall,  32'd20, 32'd30,        32'h0};
        tbl[6] = '{k_fence,  32'd26, 32'd30,        32'h0};
        tbl[7] = '{k_misp,   32'd32, 32'h0000_0300, 32'h0};
        tbl[8] = '{k_csr_ex, 32'd40, 32'h0000_0400, 32'h0000_0500};
        tbl[9] = '{k_end,    32'd50, 32'h0,         32'h0};
        foreach (tbl[i]) begin
            if (tbl[i].kind == k_mem || tbl[i].kind == k_fault) mem_words[tbl[i].a] = tbl[i].b;
            if (tbl[i].kind == k_fault) fault_addr[tbl[i].a] = 1'b1;
        end
        ev_idx = next_event(0);

        wait (!rst);
        cycles = 0;
        while (!finished && cycles < timeout_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (finished) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("t=%0t: timeout after %0d cycles, %0d packets", $time, cycles, delivered);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule

// File: design/fetch_top.sv
module fetch_top (
    input  logic                       clk,
    input  logic                       rst,
    // Back-end redirects and hazards
    input  logic                       csr_redirect,
    input  logic [fetch_pkg::xlen-1:0] csr_target,
    input  logic                       ex_redirect,
    input  logic                       ex_mispredict,
    input  logic [fetch_pkg::xlen-1:0] ex_target,
    input  logic [fetch_pkg::xlen-1:0] ex_saved_pc,
    input  logic [1:0]                 hazard,
    input  logic                       fence,
    // AXI4-Lite read channels
    output logic [fetch_pkg::xlen-1:0] araddr,
    output logic                       arvalid,
    input  logic                       arready,
    input  logic [fetch_pkg::xlen-1:0] rdata,
    input  logic [1:0]                 rresp,
    input  logic                       rvalid,
    output logic                       rready,
    // Fetched instructions to decode
    output logic                       instr_valid,
    input  logic                       instr_ready,
    output logic [fetch_pkg::xlen-1:0] instr_pc,
    output logic [fetch_pkg::xlen-1:0] instr_data,
    output logic                       instr_pred_taken,
    output logic                       instr_fault
);
    logic [fetch_pkg::xlen-1:0] pc;
    logic                       epoch;
    logic                       fetch_stall;
    logic                       issue;
    logic                       early_redirect;
    logic [fetch_pkg::xlen-1:0] early_target;
    logic                       consume;

    fetch_stream_if u_rsp_if ();

    pc_unit u_pc_unit (
        .clk            (clk),
        .rst            (rst),
        .csr_redirect   (csr_redirect),
        .csr_target     (csr_target),
        .ex_redirect    (ex_redirect),
        .ex_mispredict  (ex_mispredict),
        .ex_target      (ex_target),
        .ex_saved_pc    (ex_saved_pc),
        .early_redirect (early_redirect),
        .early_target   (early_target),
        .hazard         (hazard),
        .fence          (fence),
        .issue          (issue),
        .pc             (pc),
        .epoch          (epoch),
        .fetch_stall    (fetch_stall)
    );

    fetch_axi_master u_axi_master (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .epoch       (epoch),
        .fetch_stall (fetch_stall),
        .issue       (issue),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .consume     (consume),
        .rsp         (u_rsp_if.source)
    );

    early_branch u_early_branch (
        .clk              (clk),
        .rst              (rst),
        .epoch            (epoch),
        .rsp              (u_rsp_if.sink),
        .early_redirect   (early_redirect),
        .early_target     (early_target),
        .consume          (consume),
        .instr_valid      (instr_valid),
        .instr_ready      (instr_ready),
        .instr_pc         (instr_pc),
        .instr_data       (instr_data),
        .instr_pred_taken (instr_pred_taken),
        .instr_fault      (instr_fault)
    );

endmodule

// File: design/early_branch.sv
module early_branch (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       epoch,
    fetch_stream_if.sink               rsp,
    output logic                       early_redirect,
    output logic [fetch_pkg::xlen-1:0] early_target,
    output logic                       consume,
    output logic                       instr_valid,
    input  logic                       instr_ready,
    output logic [fetch_pkg::xlen-1:0] instr_pc,
    output logic [fetch_pkg::xlen-1:0] instr_data,
    output logic                       instr_pred_taken,
    output logic                       instr_fault
);
    logic                       epoch_q;
    logic [6:0]                 opcode;
    logic [fetch_pkg::xlen-1:0] imm_j;
    logic [fetch_pkg::xlen-1:0] imm_b;
    logic                       is_jal;
    logic                       is_bwd_branch;
    logic                       shadow;
    logic                       take;
    logic                       q_empty;
    logic                       q_full;
    fetch_pkg::fetch_pkt_t      pkt_in;
    fetch_pkg::fetch_pkt_t      pkt_out;

    ////////////////////////////////////////
    // Predecode
    ////////////////////////////////////////
    assign opcode = rsp.instr[6:0];

    assign imm_j = {{11{rsp.instr[31]}}, rsp.instr[31], rsp.instr[19:12],
                    rsp.instr[20], rsp.instr[30:21], 1'b0};
    assign imm_b = {{19{rsp.instr[31]}}, rsp.instr[31], rsp.instr[7],
                    rsp.instr[30:25], rsp.instr[11:8], 1'b0};

    assign is_jal        = (opcode == fetch_pkg::opcode_jal);
    // Sign bit of the B immediate, backward means a loop
    assign is_bwd_branch = (opcode == fetch_pkg::opcode_branch) && rsp.instr[31];

    // Epoch flipped on the last edge, this word was fetched before that redirect
    always_ff @(posedge clk) begin
        if (rst) begin
            epoch_q <= 1'b0;
        end else begin
            epoch_q <= epoch;
        end
    end
    assign shadow = (epoch != epoch_q);

    assign take = rsp.valid && !rsp.fault && (is_jal || is_bwd_branch) && !shadow;

    assign early_redirect = take;
    assign early_target   = rsp.pc + (is_jal ? imm_j : imm_b);

    ////////////////////////////////////////
    // Output queue
    ////////////////////////////////////////
    assign pkt_in = '{pc:         rsp.pc,
                      instr:      rsp.instr,
                      pred_taken: take,
                      fault:      rsp.fault};

    assign consume     = instr_valid && instr_ready;
    assign instr_valid = !q_empty;

    sync_fifo #(
        .payload_t (fetch_pkg::fetch_pkt_t),
        .depth     (fetch_pkg::fetch_queue_depth)
    ) u_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (rsp.valid),
        .push_data (pkt_in),
        .pop       (consume),
        .pop_data  (pkt_out),
        .empty     (q_empty),
        .full      (q_full)
    );

    assign instr_pc         = pkt_out.pc;
    assign instr_data       = pkt_out.instr;
    assign instr_pred_taken = pkt_out.pred_taken;
    assign instr_fault      = pkt_out.fault;

    // Credits in the master must keep a free slot for every response
    a_room_for_rsp: assert property (@(posedge clk) disable iff (rst)
        rsp.valid |-> !q_full || consume)
        else $error("early_branch: response arrived with the queue full");

endmodule

// File: design/fetch_axi_master.sv
module fetch_axi_master (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [fetch_pkg::xlen-1:0] pc,
    input  logic                       epoch,
    input  logic                       fetch_stall,
    output logic                       issue,
    output logic [fetch_pkg::xlen-1:0] araddr,
    output logic                       arvalid,
    input  logic                       arready,
    input  logic [fetch_pkg::xlen-1:0] rdata,
    input  logic [1:0]                 rresp,
    input  logic                       rvalid,
    output logic                       rready,
    input  logic                       consume,
    fetch_stream_if.source             rsp
);
    localparam int cw = $clog2(fetch_pkg::max_outstanding + 1);

    logic                ar_epoch;
    logic                ar_done;
    logic                arm;
    logic                r_done;
    logic                drop;
    logic                credit_free;
    logic [cw-1:0]       credits_used;
    logic                pend_empty;
    logic                pend_full;
    fetch_pkg::pending_t pend_in;
    fetch_pkg::pending_t pend_head;

    // Every request already owns a slot downstream
    assign rready = 1'b1;

    assign ar_done     = arvalid && arready;
    assign credit_free = credits_used < cw'(fetch_pkg::max_outstanding);
    assign arm         = !arvalid && credit_free && !fetch_stall && !pend_full;

    // Only a request from the live epoch moves the PC on
    assign issue = ar_done && (ar_epoch == epoch);

    assign r_done = rvalid && rready && !pend_empty;
    assign drop   = r_done && (pend_head.epoch != epoch);

    ////////////////////////////////////////
    // Read address channel
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
        end else if (arm) begin
            arvalid <= 1'b1;
        end else if (ar_done) begin
            arvalid <= 1'b0;
        end
    end

    // Address and tag are frozen once the request is raised
    always_ff @(posedge clk) begin
        if (arm) begin
            araddr   <= pc;
            ar_epoch <= epoch;
        end
    end

    // Credit taken when arvalid rises, returned on consume or drop
    always_ff @(posedge clk) begin
        if (rst) begin
            credits_used <= '0;
        end else begin
            credits_used <= credits_used + cw'(arm) - cw'(consume) - cw'(drop);
        end
    end

    assign pend_in = '{addr: araddr, epoch: ar_epoch};

    sync_fifo #(
        .payload_t (fetch_pkg::pending_t),
        .depth     (fetch_pkg::max_outstanding)
    ) u_pending (
        .clk       (clk),
        .rst       (rst),
        .push      (ar_done),
        .push_data (pend_in),
        .pop       (r_done),
        .pop_data  (pend_head),
        .empty     (pend_empty),
        .full      (pend_full)
    );

    ////////////////////////////////////////
    // Read data channel
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= r_done && !drop;
        end
    end

    always_ff @(posedge clk) begin
        if (r_done) begin
            rsp.pc    <= pend_head.addr;
            rsp.instr <= rdata;
            rsp.fault <= (rresp != 2'b00);
        end
    end

    a_ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("fetch_axi_master: AR request changed before arready");

endmodule

// File: design/pc_unit.sv
module pc_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       csr_redirect,
    input  logic [fetch_pkg::xlen-1:0] csr_target,
    input  logic                       ex_redirect,
    input  logic                       ex_mispredict,
    input  logic [fetch_pkg::xlen-1:0] ex_target,
    input  logic [fetch_pkg::xlen-1:0] ex_saved_pc,
    input  logic                       early_redirect,
    input  logic [fetch_pkg::xlen-1:0] early_target,
    input  logic [1:0]                 hazard,
    input  logic                       fence,
    input  logic                       issue,
    output logic [fetch_pkg::xlen-1:0] pc,
    output logic                       epoch,
    output logic                       fetch_stall
);
    logic any_redirect;

    assign any_redirect = csr_redirect || ex_redirect || early_redirect;

    // Stalls only hold back new requests, redirects still land
    assign fetch_stall = (hazard == fetch_pkg::hazard_stall_early) ||
                         (hazard == fetch_pkg::hazard_stall_mmu) || fence;

    ////////////////////////////////////////
    // Next PC, highest priority first
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= fetch_pkg::reset_pc;
            epoch <= 1'b0;
        end else begin
            if (csr_redirect) begin
                pc <= csr_target;
            end else if (ex_redirect) begin
                // Mispredict recovery resumes after the branch itself
                pc <= ex_mispredict ? ex_saved_pc + 32'd4 : ex_target;
            end else if (early_redirect) begin
                pc <= early_target;
            end else if (issue) begin
                pc <= pc + 32'd4;
            end
            // New epoch marks everything already in flight as stale
            if (any_redirect) epoch <= ~epoch;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00)
        else $error("pc_unit: misaligned pc %h", pc);

endmodule

// File: design/sync_fifo.sv
module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);
    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam int cw = $clog2(depth + 1);

    payload_t      mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [cw-1:0] count;
    logic          do_push;
    logic          do_pop;

    // Wraps at depth, so depth need not be a power of two
    function automatic logic [aw-1:0] ptr_next(input logic [aw-1:0] p);
        return (p == aw'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);

    assign empty    = (count == '0);
    assign full     = (count == cw'(depth));
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_next(wr_ptr);
            if (do_pop)  rd_ptr <= ptr_next(rd_ptr);
            count <= count + cw'(do_push) - cw'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    // Callers must respect full and empty
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !(push && full && !pop))
        else $error("sync_fifo: push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        !(pop && empty))
        else $error("sync_fifo: pop while empty");

endmodule

// File: design/fetch_stream_if.sv
// Accepted read responses, one cycle per word, no back-pressure
interface fetch_stream_if;

    logic                       valid;
    logic [fetch_pkg::xlen-1:0] pc;
    logic [fetch_pkg::xlen-1:0] instr;
    logic                       fault;

    modport source (
        output valid,
        output pc,
        output instr,
        output fault
    );

    modport sink (
        input valid,
        input pc,
        input instr,
        input fault
    );

endinterface

// File: design/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////
    // Widths and reset state
    ////////////////////////////////////////
    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // Hazard codes from the back end
    localparam logic [1:0] hazard_none        = 2'd0;
    localparam logic [1:0] hazard_stall_early = 2'd1;
    localparam logic [1:0] hazard_stall_mmu   = 2'd2;

    // Credit limit and queue sizes
    localparam int max_outstanding   = 4;
    localparam int fetch_queue_depth = 4;

    // RV32I opcodes seen by predecode
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_branch = 7'b1100011;

    ////////////////////////////////////////
    // Payload types
    ////////////////////////////////////////

    // One issued read, tagged with the epoch it was issued in
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic            epoch;
    } pending_t;

    // One fetched instruction on its way to decode
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
        logic            pred_taken;
        logic            fault;
    } fetch_pkt_t;

endpackage
